// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := tb_apple1_bus
FILELIST   := files.f
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing --assert

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# exit status of the simulation binary is the test result
sim: build
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// ==== files.f ====
+incdir+hw
hw/apple1_pkg.sv
hw/sync_ram.sv
hw/clock_reset.sv
hw/bus_arbiter.sv
hw/memory_map.sv
hw/aci.sv
hw/tape_audio.sv
hw/apple1_bus_top.sv
tb/tb_apple1_bus.sv

// ==== hw/aci.sv ====
// Apple Cassette Interface
// loadable ROM page, tape bit on reads of the low page, tape out toggle
`timescale 1ns/100ps
`include "apple1_cfg.svh"

module aci
	import apple1_pkg::*;
(
	input  logic     sys_clock,
	input  logic     arst_n_i,
	input  mem_req_t mem_req_i,
	input  logic     aci_cs_i,     // 0xC000 to 0xC1FF
	input  logic     tape_in_i,    // synchronized tape level
	output data_t    rdata_o,
	output logic     tape_out_o
);

	localparam int ROM_DEPTH = `A1_ACI_TOP - `A1_ACI_ROM_BASE + 1;  // 256
	localparam int ROM_AW    = $clog2(ROM_DEPTH);

	logic  rom_half;    // upper page of the window
	logic  rom_we;
	logic  sub_q;       // last read hit the tape page
	logic  tape_q;
	logic  tape_out_q;
	data_t rom_rd;

	assign rom_half = (mem_req_i.addr >= `A1_ACI_ROM_BASE);
	assign rom_we   = aci_cs_i & rom_half & mem_req_i.we & mem_req_i.dl;  // CPU writes dropped

	// both pages read the same ROM offset
	sync_ram #(.DEPTH(ROM_DEPTH)) rom_aci (
		.sys_clock (sys_clock),
		.addr_i    (mem_req_i.addr[ROM_AW-1:0]),
		.we_i      (rom_we),
		.wdata_i   (mem_req_i.wdata),
		.rdata_o   (rom_rd)
	);

	always_ff @(posedge sys_clock or negedge arst_n_i) begin
		if (!arst_n_i) begin
			sub_q      <= 1'b0;
			tape_q     <= 1'b0;
			tape_out_q <= 1'b0;
		end else begin
			sub_q  <= aci_cs_i & ~rom_half;
			tape_q <= tape_in_i;  // sampled with the ROM read
			// any CPU access in the window flips the tape output
			if (aci_cs_i && mem_req_i.acc) begin
				tape_out_q <= ~tape_out_q;
			end
		end
	end

	// bit 0 carries the tape level on the low page
	assign rdata_o    = {rom_rd[`A1_DATA_W-1:1], sub_q ? tape_q : rom_rd[0]};
	assign tape_out_o = tape_out_q;

endmodule

// ==== hw/apple1_bus_top.sv ====
// Apple-1 system bus top level
// clock and reset, arbiter, memory map, cassette interface and audio
`timescale 1ns/100ps

module apple1_bus_top
	import apple1_pkg::*;
(
	input  logic     sys_clock,
	input  logic     arst_n_i,
	input  cpu_bus_t cpu_bus_i,      // CPU side, held per CPU cycle
	input  dl_bus_t  dl_bus_i,
	input  logic     downloading_i,
	input  logic     reset_req_i,    // menu reset
	input  logic     reset_key_i,    // keyboard reset key
	input  logic     tape_in_i,      // cassette in, active low
	input  logic     mon_tape_in_i,
	output logic     cpu_clken_o,
	output logic     cpu_reset_o,
	output data_t    rdata_o,
	output logic     tape_out_o,
	output logic     led_o,
	output logic     audio_o
);

	mem_req_t mem_req;
	logic     aci_cs;
	data_t    aci_rdata;
	logic     tape_sync;

	clock_reset u_clock_reset (
		.sys_clock     (sys_clock),
		.arst_n_i      (arst_n_i),
		.downloading_i (downloading_i),
		.reset_req_i   (reset_req_i),
		.reset_key_i   (reset_key_i),
		.cpu_clken_o   (cpu_clken_o),
		.cpu_reset_o   (cpu_reset_o)
	);

	bus_arbiter u_bus_arbiter (
		.sys_clock     (sys_clock),
		.arst_n_i      (arst_n_i),
		.cpu_bus_i     (cpu_bus_i),
		.cpu_clken_i   (cpu_clken_o),
		.dl_bus_i      (dl_bus_i),
		.downloading_i (downloading_i),
		.mem_req_o     (mem_req),
		.led_o         (led_o)
	);

	memory_map u_memory_map (
		.sys_clock   (sys_clock),
		.arst_n_i    (arst_n_i),
		.mem_req_i   (mem_req),
		.aci_rdata_i (aci_rdata),
		.aci_cs_o    (aci_cs),
		.rdata_o     (rdata_o)
	);

	aci u_aci (
		.sys_clock  (sys_clock),
		.arst_n_i   (arst_n_i),
		.mem_req_i  (mem_req),
		.aci_cs_i   (aci_cs),
		.tape_in_i  (tape_sync),   // loops back from the synchronizer
		.rdata_o    (aci_rdata),
		.tape_out_o (tape_out_o)
	);

	tape_audio u_tape_audio (
		.sys_clock     (sys_clock),
		.arst_n_i      (arst_n_i),
		.tape_in_i     (tape_in_i),
		.tape_out_i    (tape_out_o),
		.mon_tape_in_i (mon_tape_in_i),
		.tape_sync_o   (tape_sync),
		.audio_o       (audio_o)
	);

endmodule

// ==== hw/apple1_cfg.svh ====
// Apple-1 bus configuration
// memory map, CPU clock divider, reset stretch and audio DAC size
`ifndef APPLE1_CFG_SVH
`define APPLE1_CFG_SVH

// bus widths
`define A1_ADDR_W        16
`define A1_DATA_W        8

`define A1_CPU_DIV       8     // sys_clock cycles per CPU cycle
`define A1_RESET_CYCLES  16    // CPU reset stretch after last trigger
`define A1_DAC_BITS      16    // sigma-delta accumulator

// low system RAM, 16K
`define A1_RAM_LO_BASE   16'h0000
`define A1_RAM_LO_TOP    16'h3FFF
// expansion RAM, stands in for the SDRAM window, 32K
`define A1_EXP_BASE      16'h4000
`define A1_EXP_TOP       16'hBFFF
// cassette interface, tape page then ROM page
`define A1_ACI_BASE      16'hC000
`define A1_ACI_TOP       16'hC1FF
`define A1_ACI_ROM_BASE  16'hC100
// BASIC RAM, 4K
`define A1_BASIC_BASE    16'hE000
`define A1_BASIC_TOP     16'hEFFF
// monitor ROM, last page up to 0xFFFF
`define A1_MON_BASE      16'hFF00

`endif

// ==== hw/apple1_pkg.sv ====
// Apple-1 bus types
// request structs for CPU, download port and arbitrated bus
`include "apple1_cfg.svh"

package apple1_pkg;

	typedef logic [`A1_ADDR_W-1:0] addr_t;
	typedef logic [`A1_DATA_W-1:0] data_t;

	typedef logic [$clog2(`A1_CPU_DIV)-1:0]        div_cnt_t;  // CPU cycle phase
	typedef logic [$clog2(`A1_RESET_CYCLES+1)-1:0] rst_cnt_t;  // reset stretch

	// audio monitor source
	typedef enum logic {
		MON_TAPE_OUT = 1'b0,
		MON_TAPE_IN  = 1'b1
	} mon_src_t;

	// CPU side, held for a whole CPU cycle
	typedef struct packed {
		addr_t addr;
		data_t wdata;
		logic  we;     // write level
	} cpu_bus_t;

	// download port, wr is a single sys_clock pulse
	typedef struct packed {
		addr_t addr;
		data_t data;
		logic  wr;
	} dl_bus_t;

	typedef struct packed {
		addr_t addr;
		data_t wdata;
		logic  we;     // write strobe
		logic  acc;    // CPU cycle access strobe
		logic  dl;     // request came from download
	} mem_req_t;

endpackage

// ==== hw/bus_arbiter.sv ====
// system bus arbiter
// download port takes the bus from the CPU, drives the activity LED
`timescale 1ns/100ps

module bus_arbiter
	import apple1_pkg::*;
(
	input  logic     sys_clock,
	input  logic     arst_n_i,
	input  cpu_bus_t cpu_bus_i,
	input  logic     cpu_clken_i,    // one pulse per CPU cycle
	input  dl_bus_t  dl_bus_i,
	input  logic     downloading_i,
	output mem_req_t mem_req_o,
	output logic     led_o           // active low
);

	addr_t addr_q;
	data_t wdata_q;
	logic  we_q;
	logic  acc_q;
	logic  dl_q;
	logic  dl_win;   // download write owns this cycle

	assign dl_win = downloading_i & dl_bus_i.wr;

	// address and data, no reset needed
	always_ff @(posedge sys_clock) begin
		if (dl_win) begin
			addr_q  <= dl_bus_i.addr;
			wdata_q <= dl_bus_i.data;
		end else begin
			addr_q  <= cpu_bus_i.addr;   // CPU address forwarded every cycle
			wdata_q <= cpu_bus_i.wdata;
		end
	end

	always_ff @(posedge sys_clock or negedge arst_n_i) begin
		if (!arst_n_i) begin
			we_q  <= 1'b0;
			acc_q <= 1'b0;
			dl_q  <= 1'b0;
		end else if (dl_win) begin
			we_q  <= 1'b1;
			acc_q <= 1'b0;  // not a CPU cycle
			dl_q  <= 1'b1;
		end else begin
			we_q  <= cpu_bus_i.we & cpu_clken_i & ~downloading_i;  // one strobe per cycle
			acc_q <= cpu_clken_i & ~downloading_i;
			dl_q  <= 1'b0;
		end
	end

	assign mem_req_o = '{addr: addr_q, wdata: wdata_q, we: we_q, acc: acc_q, dl: dl_q};

	assign led_o = ~(we_q & dl_q);  // lit for each registered download write

	// CPU writes stay off the bus for the whole download
	a_no_cpu_write_in_dl: assert property (@(posedge sys_clock) disable iff (!arst_n_i)
		downloading_i |=> !(mem_req_o.we && !mem_req_o.dl));

endmodule

// ==== hw/clock_reset.sv ====
// CPU clock enable and reset control
// divides sys_clock into CPU cycles, stretches menu and key resets
`timescale 1ns/100ps
`include "apple1_cfg.svh"

module clock_reset
	import apple1_pkg::*;
(
	input  logic sys_clock,
	input  logic arst_n_i,
	input  logic downloading_i,  // download owns the bus
	input  logic reset_req_i,    // menu reset level
	input  logic reset_key_i,    // keyboard reset key level
	output logic cpu_clken_o,
	output logic cpu_reset_o
);

	div_cnt_t div_cnt;   // phase inside the CPU cycle
	rst_cnt_t rst_cnt;   // cycles of reset still to go
	logic     key_q;     // key level seen last cycle
	logic     key_rise;
	logic     rst_trig;
	logic     div_last;

	assign div_last = (div_cnt == div_cnt_t'(`A1_CPU_DIV - 1));

	// free running, keeps counting while the pulse is masked
	always_ff @(posedge sys_clock or negedge arst_n_i) begin
		if (!arst_n_i) begin
			div_cnt <= '0;
		end else if (div_last) begin
			div_cnt <= '0;
		end else begin
			div_cnt <= div_cnt + 1'b1;
		end
	end

	// key must be seen low before a press counts, held key fires once
	assign key_rise = reset_key_i & ~key_q;
	assign rst_trig = reset_req_i | key_rise;

	always_ff @(posedge sys_clock or negedge arst_n_i) begin
		if (!arst_n_i) begin
			key_q   <= 1'b1;
			rst_cnt <= rst_cnt_t'(`A1_RESET_CYCLES);  // CPU starts in reset
		end else begin
			key_q <= reset_key_i;
			if (rst_trig) begin
				rst_cnt <= rst_cnt_t'(`A1_RESET_CYCLES);  // restart stretch
			end else if (rst_cnt != '0) begin
				rst_cnt <= rst_cnt - 1'b1;
			end
		end
	end

	assign cpu_reset_o = (rst_cnt != '0);
	assign cpu_clken_o = div_last & ~downloading_i & ~cpu_reset_o;  // masked pulse

	// CPU never sees two cycles in a row
	a_clken_spacing: assert property (@(posedge sys_clock) disable iff (!arst_n_i)
		cpu_clken_o |=> !cpu_clken_o);

	// last cycle of the stretch still holds the CPU
	a_clken_in_reset: assert property (@(posedge sys_clock) disable iff (!arst_n_i)
		rst_trig |-> ##(`A1_RESET_CYCLES) (cpu_reset_o && !cpu_clken_o));

endmodule

// ==== hw/memory_map.sv ====
// Apple-1 memory map
// decodes RAM, ROM and ACI windows, write protects the monitor ROM,
// muxes the registered read data back to the CPU
`timescale 1ns/100ps
`include "apple1_cfg.svh"

module memory_map
	import apple1_pkg::*;
(
	input  logic     sys_clock,
	input  logic     arst_n_i,
	input  mem_req_t mem_req_i,
	input  data_t    aci_rdata_i,  // already registered inside aci
	output logic     aci_cs_o,
	output data_t    rdata_o
);

	localparam int LO_DEPTH    = `A1_RAM_LO_TOP - `A1_RAM_LO_BASE + 1;  // 16K
	localparam int EXP_DEPTH   = `A1_EXP_TOP - `A1_EXP_BASE + 1;        // 32K
	localparam int BASIC_DEPTH = `A1_BASIC_TOP - `A1_BASIC_BASE + 1;    // 4K
	localparam int MON_DEPTH   = 2 ** `A1_ADDR_W - `A1_MON_BASE;        // 256
	localparam int LO_AW       = $clog2(LO_DEPTH);
	localparam int EXP_AW      = $clog2(EXP_DEPTH);
	localparam int BASIC_AW    = $clog2(BASIC_DEPTH);
	localparam int MON_AW      = $clog2(MON_DEPTH);

	function automatic logic in_window(input addr_t a, input addr_t lo, input addr_t hi);
		return (a >= lo) && (a <= hi);
	endfunction

	logic              lo_cs, exp_cs, basic_cs, mon_cs;
	logic              lo_q, exp_q, aci_q, basic_q, mon_q;  // selects of the last cycle
	logic [EXP_AW-1:0] exp_off;
	data_t             lo_rd, exp_rd, basic_rd, mon_rd;

	assign lo_cs    = in_window(mem_req_i.addr, `A1_RAM_LO_BASE, `A1_RAM_LO_TOP);
	assign exp_cs   = in_window(mem_req_i.addr, `A1_EXP_BASE, `A1_EXP_TOP);
	assign aci_cs_o = in_window(mem_req_i.addr, `A1_ACI_BASE, `A1_ACI_TOP);
	assign basic_cs = in_window(mem_req_i.addr, `A1_BASIC_BASE, `A1_BASIC_TOP);
	assign mon_cs   = in_window(mem_req_i.addr, `A1_MON_BASE, {`A1_ADDR_W{1'b1}});

	assign exp_off = EXP_AW'(mem_req_i.addr - `A1_EXP_BASE);  // window relative

	sync_ram #(.DEPTH(LO_DEPTH)) ram_lo (
		.sys_clock (sys_clock),
		.addr_i    (mem_req_i.addr[LO_AW-1:0]),
		.we_i      (mem_req_i.we & lo_cs),
		.wdata_i   (mem_req_i.wdata),
		.rdata_o   (lo_rd)
	);

	sync_ram #(.DEPTH(EXP_DEPTH)) ram_exp (
		.sys_clock (sys_clock),
		.addr_i    (exp_off),
		.we_i      (mem_req_i.we & exp_cs),
		.wdata_i   (mem_req_i.wdata),
		.rdata_o   (exp_rd)
	);

	sync_ram #(.DEPTH(BASIC_DEPTH)) ram_basic (
		.sys_clock (sys_clock),
		.addr_i    (mem_req_i.addr[BASIC_AW-1:0]),
		.we_i      (mem_req_i.we & basic_cs),
		.wdata_i   (mem_req_i.wdata),
		.rdata_o   (basic_rd)
	);

	// monitor loads only from the download port
	sync_ram #(.DEPTH(MON_DEPTH)) rom_mon (
		.sys_clock (sys_clock),
		.addr_i    (mem_req_i.addr[MON_AW-1:0]),
		.we_i      (mem_req_i.we & mem_req_i.dl & mon_cs),
		.wdata_i   (mem_req_i.wdata),
		.rdata_o   (mon_rd)
	);

	// selects line up with the registered RAM outputs
	always_ff @(posedge sys_clock or negedge arst_n_i) begin
		if (!arst_n_i) begin
			{lo_q, exp_q, aci_q, basic_q, mon_q} <= '0;
		end else begin
			{lo_q, exp_q, aci_q, basic_q, mon_q} <= {lo_cs, exp_cs, aci_cs_o, basic_cs, mon_cs};
		end
	end

	always_comb begin
		if (mon_q)        rdata_o = mon_rd;
		else if (basic_q) rdata_o = basic_rd;
		else if (aci_q)   rdata_o = aci_rdata_i;
		else if (exp_q)   rdata_o = exp_rd;
		else if (lo_q)    rdata_o = lo_rd;
		else              rdata_o = '0;   // unmapped hole
	end

	a_one_select: assert property (@(posedge sys_clock) disable iff (!arst_n_i)
		$onehot0({lo_cs, exp_cs, aci_cs_o, basic_cs, mon_cs}));

endmodule

// ==== hw/sync_ram.sv ====
// synchronous single port byte RAM
// write on the clock edge, registered read of the old contents
`timescale 1ns/100ps
`include "apple1_cfg.svh"

module sync_ram #(
	parameter int DEPTH = 256   // power of two
) (
	input  logic                     sys_clock,
	input  logic [$clog2(DEPTH)-1:0] addr_i,
	input  logic                     we_i,
	input  logic [`A1_DATA_W-1:0]    wdata_i,
	output logic [`A1_DATA_W-1:0]    rdata_o
);

	logic [`A1_DATA_W-1:0] mem [DEPTH];  // contents undefined until loaded

	always_ff @(posedge sys_clock) begin
		if (we_i) begin
			mem[addr_i] <= wdata_i;
		end
		rdata_o <= mem[addr_i];  // read before write
	end

endmodule

// ==== hw/tape_audio.sv ====
// cassette audio monitor
// synchronizes tape in, picks the monitor source, 1-bit sigma-delta DAC
`timescale 1ns/100ps
`include "apple1_cfg.svh"

module tape_audio
	import apple1_pkg::*;
#(
	parameter int DAC_BITS = `A1_DAC_BITS
) (
	input  logic sys_clock,
	input  logic arst_n_i,
	input  logic tape_in_i,      // active low, async to sys_clock
	input  logic tape_out_i,
	input  logic mon_tape_in_i,  // 1 listens to tape in
	output logic tape_sync_o,
	output logic audio_o
);

	logic [1:0]        sync_q;   // two flop synchronizer
	logic [DAC_BITS-1:0] dac_acc;
	logic [DAC_BITS:0]   dac_sum;
	logic              audio_q;
	logic              mon_bit;
	mon_src_t          mon_src;

	always_ff @(posedge sys_clock or negedge arst_n_i) begin
		if (!arst_n_i) begin
			sync_q <= 2'b11;  // idle line is high
		end else begin
			sync_q <= {sync_q[0], tape_in_i};
		end
	end

	assign tape_sync_o = ~sync_q[1];  // active high tape level

	assign mon_src = mon_src_t'(mon_tape_in_i);
	assign mon_bit = (mon_src == MON_TAPE_IN) ? tape_sync_o : tape_out_i;

	// selected bit as MSB, half scale when high
	assign dac_sum = {1'b0, dac_acc} + {1'b0, mon_bit, {(DAC_BITS-1){1'b0}}};

	always_ff @(posedge sys_clock or negedge arst_n_i) begin
		if (!arst_n_i) begin
			dac_acc <= '0;
			audio_q <= 1'b0;
		end else begin
			dac_acc <= dac_sum[DAC_BITS-1:0];
			audio_q <= dac_sum[DAC_BITS];  // carry is the 1-bit stream
		end
	end

	assign audio_o = audio_q;

endmodule

// ==== tb/tb_apple1_bus.sv ====
// Apple-1 system bus testbench
// downloads all of memory, then plays the CPU against a reference model
`timescale 1ns/100ps
`include "apple1_cfg.svh"

module tb_apple1_bus
	import apple1_pkg::*;
();

	localparam int    TIMEOUT_CYCLES = 65536 + 2000 * `A1_CPU_DIV * 2;
	localparam addr_t IDLE_ADDR      = 16'hD000;  // unmapped, no ACI toggle

	logic     sys_clock;
	logic     arst_n_i;
	cpu_bus_t cpu_bus;
	dl_bus_t  dl_bus;
	logic     downloading, reset_req, reset_key, tape_in, mon_tape_in;
	logic     cpu_clken_o, cpu_reset_o, tape_out_o, led_o, audio_o;
	data_t    rdata_o;

	data_t       ref_mem [65536];  // expected contents per address
	logic        tape_bit_ref;     // model of the tape out flop
	logic [31:0] lcg_state = 32'hcd40_b0f0;
	int          cycle_count = 0;

	apple1_bus_top UUT (
		.sys_clock     (sys_clock),
		.arst_n_i      (arst_n_i),
		.cpu_bus_i     (cpu_bus),
		.dl_bus_i      (dl_bus),
		.downloading_i (downloading),
		.reset_req_i   (reset_req),
		.reset_key_i   (reset_key),
		.tape_in_i     (tape_in),
		.mon_tape_in_i (mon_tape_in),
		.cpu_clken_o   (cpu_clken_o),
		.cpu_reset_o   (cpu_reset_o),
		.rdata_o       (rdata_o),
		.tape_out_o    (tape_out_o),
		.led_o         (led_o),
		.audio_o       (audio_o)
	);

	always #10 sys_clock = ~sys_clock;  // 20 ns period

	// run limit, download plus CPU cycles with margin
	always @(posedge sys_clock) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("Test failures found");
			$fatal(1, "timeout, run did not finish within %0d cycles", TIMEOUT_CYCLES);
		end
	end

	task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
		input string what);
		if (actual !== expected) begin
			$display("ERROR at %0t ns: %s, got 0x%0h, expected 0x%0h",
				$time, what, actual, expected);
			$display("Test failures found");
			$fatal(1, "stopped at first mismatch");
		end
	endtask

	function automatic logic [31:0] next_random();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;  // numerical recipes LCG
		return lcg_state;
	endfunction

	function automatic logic in_range(input addr_t a, input addr_t lo, input addr_t hi);
		return (a >= lo) && (a <= hi);
	endfunction

	function automatic logic cpu_writable(input addr_t a);
		return in_range(a, `A1_RAM_LO_BASE, `A1_RAM_LO_TOP) ||
			in_range(a, `A1_EXP_BASE, `A1_EXP_TOP) ||
			in_range(a, `A1_BASIC_BASE, `A1_BASIC_TOP);
	endfunction

	// RAM plus the two ROMs that only the download port fills
	function automatic logic loadable(input addr_t a);
		return cpu_writable(a) || in_range(a, `A1_MON_BASE, {`A1_ADDR_W{1'b1}}) ||
			in_range(a, `A1_ACI_ROM_BASE, `A1_ACI_TOP);
	endfunction

	function automatic logic in_aci(input addr_t a);
		return in_range(a, `A1_ACI_BASE, `A1_ACI_TOP);
	endfunction

	function automatic data_t expected_read(input addr_t a);
		data_t rom_byte;
		if (loadable(a)) begin
			return ref_mem[a];
		end else if (in_aci(a)) begin
			rom_byte = ref_mem[`A1_ACI_ROM_BASE + {8'h00, a[7:0]}];  // same page offset
			return {rom_byte[7:1], ~tape_in};                      // tape level on bit 0
		end
		return 8'h00;  // hole in the map
	endfunction

	function automatic addr_t pick_in(input addr_t lo, input addr_t hi);
		logic [31:0] r;
		r = next_random();
		return lo + addr_t'((r >> 8) % (32'(hi) - 32'(lo) + 32'd1));  // upper bits, better spread
	endfunction

	function automatic addr_t random_addr();
		logic [31:0] r;
		r = next_random();
		case ((r >> 16) % 6)
			0:       return pick_in(`A1_RAM_LO_BASE, `A1_RAM_LO_TOP);
			1:       return pick_in(`A1_EXP_BASE, `A1_EXP_TOP);
			2:       return pick_in(`A1_ACI_BASE, `A1_ACI_TOP);
			3:       return pick_in(`A1_BASIC_BASE, `A1_BASIC_TOP);
			4:       return pick_in(`A1_MON_BASE, {`A1_ADDR_W{1'b1}});
			default: return pick_in(addr_t'(`A1_ACI_TOP + 1), addr_t'(`A1_BASIC_BASE - 1));
		endcase
	endfunction

	// returns on the falling edge inside an enable cycle
	task automatic wait_clken();
		@(negedge sys_clock);
		while (!cpu_clken_o) @(negedge sys_clock);
	endtask

	task automatic align_cycle();
		wait_clken();
		@(posedge sys_clock);
		#2;
	endtask

	// one CPU cycle, entered and left 2 ns after an enable edge
	task automatic cpu_access(input addr_t addr, input data_t wdata, input logic we,
		output data_t rdata);
		cpu_bus = '{addr: addr, wdata: wdata, we: we};
		wait_clken();
		rdata = rdata_o;  // address held for the whole cycle
		check_value(32'(tape_out_o), 32'(tape_bit_ref), "tape out level");
		@(posedge sys_clock);
		if (in_aci(addr)) tape_bit_ref = ~tape_bit_ref;  // read or write both toggle
		#2;
		cpu_bus = '{addr: IDLE_ADDR, wdata: 8'h00, we: 1'b0};
	endtask

	task automatic count_reset_cycles(output int n);
		n = 0;
		@(negedge sys_clock);
		while (cpu_reset_o) begin
			n++;
			check_value(32'(cpu_clken_o), 0, "enable pulse during CPU reset");
			@(negedge sys_clock);
		end
	endtask

	// ones in the DAC stream over 64 cycles
	task automatic check_audio_level(input logic level, input string what);
		int ones;
		ones = 0;
		repeat (64) begin
			@(negedge sys_clock);
			if (audio_o) ones++;
		end
		if (level) check_value(32'(ones >= 31 && ones <= 33), 1, what);  // half duty
		else check_value(32'(ones), 0, what);
	endtask

	initial begin
		data_t rd;
		data_t d;
		addr_t a;
		int    led_low;
		int    n;
		int    last_cycle;
		sys_clock    = 1'b0;
		arst_n_i     = 1'b0;
		cpu_bus      = '{addr: IDLE_ADDR, wdata: 8'h00, we: 1'b0};
		dl_bus       = '{addr: 16'h0000, data: 8'h00, wr: 1'b0};
		downloading  = 1'b0;
		reset_req    = 1'b0;
		reset_key    = 1'b0;
		tape_in      = 1'b1;  // idle cassette line
		mon_tape_in  = 1'b0;
		tape_bit_ref = 1'b0;
		led_low      = 0;
		repeat (3) @(posedge sys_clock);
		#2;
		arst_n_i = 1'b1;
		@(negedge sys_clock);
		check_value(32'(cpu_reset_o), 1, "CPU reset after power on");
		while (cpu_reset_o) @(negedge sys_clock);
		@(posedge sys_clock);
		#2;

		// fill every address through the download port, one strobe per cycle
		downloading = 1'b1;
		for (int i = 0; i < 65536; i++) begin
			a = addr_t'(i);
			d = data_t'(next_random() >> 24);
			dl_bus = '{addr: a, data: d, wr: 1'b1};
			if (loadable(a)) ref_mem[a] = d;
			@(negedge sys_clock);
			if (!led_o) led_low++;
			check_value(32'(cpu_clken_o), 0, "enable pulse during download");
			@(posedge sys_clock);
			#2;
		end
		dl_bus.wr = 1'b0;
		repeat (4) begin
			@(negedge sys_clock);
			if (!led_o) led_low++;  // last write shows up here
		end
		check_value(32'(led_low), 65536, "LED low cycles during download");
		@(posedge sys_clock);
		#2;
		downloading = 1'b0;

		align_cycle();
		repeat (300) begin
			a = random_addr();
			cpu_access(a, 8'h00, 1'b0, rd);
			check_value(32'(rd), 32'(expected_read(a)), $sformatf("read 0x%04h", a));
		end

		// CPU writes land in RAM only
		repeat (150) begin
			a = random_addr();
			d = data_t'(next_random() >> 24);
			cpu_access(a, d, 1'b1, rd);
			if (cpu_writable(a)) ref_mem[a] = d;
			cpu_access(a, 8'h00, 1'b0, rd);
			check_value(32'(rd), 32'(expected_read(a)), $sformatf("read back 0x%04h", a));
		end

		// tape page with both input levels
		for (int lvl = 0; lvl < 2; lvl++) begin
			tape_in = lvl[0];
			align_cycle();
			repeat (64) begin
				a = pick_in(`A1_ACI_BASE, addr_t'(`A1_ACI_ROM_BASE - 1));
				cpu_access(a, 8'h00, 1'b0, rd);
				check_value(32'(rd), 32'(expected_read(a)), $sformatf("tape page 0x%04h", a));
			end
		end

		wait_clken();
		last_cycle = cycle_count;
		repeat (6) begin
			wait_clken();
			check_value(cycle_count - last_cycle, `A1_CPU_DIV, "enable pulse spacing");
			last_cycle = cycle_count;
		end

		// menu reset, one cycle pulse
		@(posedge sys_clock);
		#2;
		reset_req = 1'b1;
		@(posedge sys_clock);
		#2;
		reset_req = 1'b0;
		count_reset_cycles(n);
		check_value(n, `A1_RESET_CYCLES, "reset length after menu reset");

		// key press, held long past the stretch
		@(posedge sys_clock);
		#2;
		reset_key = 1'b1;
		@(posedge sys_clock);
		#2;
		count_reset_cycles(n);
		check_value(n, `A1_RESET_CYCLES, "reset length after key press");
		repeat (40) begin
			@(negedge sys_clock);
			check_value(32'(cpu_reset_o), 0, "held key retriggered reset");
		end
		@(posedge sys_clock);
		#2;
		reset_key = 1'b0;

		// audio monitor on tape in, line high then low
		mon_tape_in = 1'b1;
		tape_in     = 1'b1;
		repeat (8) @(posedge sys_clock);
		check_audio_level(1'b0, "audio with tape level 0");
		@(posedge sys_clock);
		#2;
		tape_in = 1'b0;
		repeat (8) @(posedge sys_clock);
		check_audio_level(1'b1, "audio with tape level 1");
		@(posedge sys_clock);
		#2;
		tape_in = 1'b1;

		// monitor on tape out, both levels through one ACI access
		@(posedge sys_clock);
		#2;
		mon_tape_in = 1'b0;
		repeat (4) @(posedge sys_clock);
		check_audio_level(tape_bit_ref, "audio from tape out");
		align_cycle();
		cpu_access(`A1_ACI_BASE, 8'h00, 1'b0, rd);
		repeat (4) @(posedge sys_clock);
		check_audio_level(tape_bit_ref, "audio from toggled tape out");

		$display("All tests passed!");
		$finish;
	end

endmodule
